//--- list.f
+incdir+include
verilog/input_pkg.sv
verilog/rom_pkg.sv
verilog/key_decoder.sv
verilog/control_mapper.sv
verilog/load_sequencer.sv
verilog/rom_store.sv
verilog/arcade_io_top.sv
sim/arcade_io_assert.sv
sim/arcade_io_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the arcade I/O testbench with Verilator and run it.
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	-f list.f --top-module arcade_io_tb -o arcade_io_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/arcade_io_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation ended with status $status"
	exit 1
fi

echo "Simulation finished with status 0"
exit 0

//--- sim/arcade_io_tb.sv
`default_nettype none

`include "arcade_params.svh"

module arcade_io_tb;

	timeunit 1ns;
	timeprecision 1ps;

	import input_pkg::*;
	import rom_pkg::*;

	localparam int NUM_WRITES = 200;
	localparam int NUM_EVENTS = 150;

	logic       clk_sys, rst_n;
	logic       key_strobe, key_pressed;
	scan_code_t key_code;
	joy_t       joystick_0, joystick_1;
	logic       rotate, user_reset, dl_active, dl_wr;
	rom_addr_t  dl_addr, rom_rd_addr;
	rom_data_t  dl_data, rom_rd_data;
	logic       ctl_up, ctl_down, ctl_left, ctl_right, ctl_fire, ctl_bomb;
	logic       ctl_coin, ctl_start1, ctl_start2;
	logic       rom_loaded, core_reset, load_overrun;

	integer seed = 32'hbe4a;

	// Reference model
	rom_data_t                        model_mem [1 << `ROM_ADDR_W];
	logic [(1 << `ROM_ADDR_W)-1:0]    written_flag;
	rom_addr_t                        written [$];   // Each written address once
	buttons_t                         model_btn;
	scan_code_t key_table [9] = '{`KEY_UP, `KEY_DOWN, `KEY_LEFT, `KEY_RIGHT, `KEY_COIN,
		`KEY_START1, `KEY_START2, `KEY_FIRE1, `KEY_FIRE2};

	arcade_io_top DUT (.*);

	bind load_sequencer arcade_io_assert u_seq_assert (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.wr_req     (wr_req),
		.wr_ack     (wr_ack),
		.rom_loaded (rom_loaded),
		.core_reset (core_reset)
	);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	function automatic logic [31:0] rand32();
		rand32 = $random(seed);
	endfunction

	// Controls as {up, down, left, right, fire, bomb, coin, start1, start2}
	function automatic logic [8:0] expect_controls();
		logic up, down, left, right, fire, bomb;
		up    = model_btn[0] | joystick_0[`JOY_UP]    | joystick_1[`JOY_UP];
		down  = model_btn[1] | joystick_0[`JOY_DOWN]  | joystick_1[`JOY_DOWN];
		left  = model_btn[2] | joystick_0[`JOY_LEFT]  | joystick_1[`JOY_LEFT];
		right = model_btn[3] | joystick_0[`JOY_RIGHT] | joystick_1[`JOY_RIGHT];
		fire  = model_btn[7] | joystick_0[`JOY_FIRE]  | joystick_1[`JOY_FIRE];
		bomb  = model_btn[8] | joystick_0[`JOY_BOMB]  | joystick_1[`JOY_BOMB];
		if (rotate)
			return {left, right, down, up, fire, bomb, model_btn[4], model_btn[5], model_btn[6]};
		return {up, down, left, right, fire, bomb, model_btn[4], model_btn[5], model_btn[6]};
	endfunction

	task automatic stop_on_error(input string reason);
		$display("%s", reason);
		$display("TB FAILED");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected)
			stop_on_error($sformatf("[FAIL] %s got 0x%0h expected 0x%0h", name, got, expected));
	endtask

	task automatic check_controls();
		logic [8:0] exp;
		exp = expect_controls();
		check_value("ctl_up", 32'(ctl_up), 32'(exp[8]));
		check_value("ctl_down", 32'(ctl_down), 32'(exp[7]));
		check_value("ctl_left", 32'(ctl_left), 32'(exp[6]));
		check_value("ctl_right", 32'(ctl_right), 32'(exp[5]));
		check_value("ctl_fire", 32'(ctl_fire), 32'(exp[4]));
		check_value("ctl_bomb", 32'(ctl_bomb), 32'(exp[3]));
		check_value("ctl_coin", 32'(ctl_coin), 32'(exp[2]));
		check_value("ctl_start1", 32'(ctl_start1), 32'(exp[1]));
		check_value("ctl_start2", 32'(ctl_start2), 32'(exp[0]));
	endtask

	task automatic wait_ack(input logic level, input string what);
		int n;
		n = 0;
		while (DUT.wr_ack !== level) begin
			if (n == 20)
				stop_on_error($sformatf("Timed out waiting for %s", what));
			@(negedge clk_sys);
			n++;
		end
	endtask

	task automatic wait_loaded();
		int n;
		n = 0;
		while (rom_loaded !== 1'b1) begin
			if (n == 20)
				stop_on_error("Timed out waiting for rom_loaded after the download ended");
			@(negedge clk_sys);
			n++;
		end
	endtask

	// One download byte, then a gap so writes sit 8 or more cycles apart
	task automatic download_byte(input rom_addr_t addr, input rom_data_t data);
		logic [31:0] r;
		dl_wr   = 1'b1;
		dl_addr = addr;
		dl_data = data;
		@(negedge clk_sys);
		dl_wr = 1'b0;
		wait_ack(1'b1, "wr_ack to rise");
		wait_ack(1'b0, "wr_ack to fall");
		model_mem[addr] = data;
		if (!written_flag[addr]) begin
			written_flag[addr] = 1'b1;
			written.push_back(addr);
		end
		r = rand32();
		repeat (4 + r[1:0]) @(negedge clk_sys);
	endtask

	task automatic check_read(input rom_addr_t addr);
		rom_rd_addr = addr;
		@(negedge clk_sys);   // Data one cycle later
		check_value($sformatf("rom_rd_data[0x%0h]", addr), 32'(rom_rd_data), 32'(model_mem[addr]));
	endtask

	// Strobe one key event and wait until it reaches the controls
	task automatic key_event(input scan_code_t code, input logic pressed);
		key_strobe  = 1'b1;
		key_code    = code;
		key_pressed = pressed;
		for (int i = 0; i < 9; i++)
			if (key_table[i] == code)
				model_btn[i] = pressed;
		@(negedge clk_sys);
		key_strobe = 1'b0;
		@(negedge clk_sys);
	endtask

	initial begin
		logic [31:0] r;
		int          idx;
		rom_addr_t   a, b;
		rom_data_t   d2;
		rst_n        = 1'b0;
		key_strobe   = 1'b0;
		key_pressed  = 1'b0;
		key_code     = '0;
		joystick_0   = '0;
		joystick_1   = '0;
		rotate       = 1'b0;
		user_reset   = 1'b0;
		dl_active    = 1'b0;
		dl_wr        = 1'b0;
		dl_addr      = '0;
		dl_data      = '0;
		rom_rd_addr  = '0;
		model_btn    = '0;
		written_flag = '0;
		repeat (5) @(posedge clk_sys);
		@(negedge clk_sys);
		rst_n = 1'b1;
		@(negedge clk_sys);

		// ========================================
		// Reset values and download
		// ========================================
		check_controls();
		check_value("rom_loaded", 32'(rom_loaded), 32'h0);
		check_value("core_reset", 32'(core_reset), 32'h1);
		check_value("load_overrun", 32'(load_overrun), 32'h0);
		dl_active = 1'b1;
		@(negedge clk_sys);
		for (int i = 0; i < NUM_WRITES; i++) begin
			r = rand32();
			download_byte(r[`ROM_ADDR_W-1:0], r[31:24]);
		end
		dl_active = 1'b0;
		wait_loaded();
		check_value("load_overrun", 32'(load_overrun), 32'h0);
		user_reset = 1'b1;
		@(negedge clk_sys);
		check_value("core_reset", 32'(core_reset), 32'h1);
		user_reset = 1'b0;
		@(negedge clk_sys);
		check_value("core_reset", 32'(core_reset), 32'h0);
		for (int i = 0; i < written.size(); i++)
			check_read(written[i]);

		// ========================================
		// Keys, then mapping with rotation
		// ========================================
		for (int i = 0; i < NUM_EVENTS; i++) begin
			r = rand32();
			if (r[1:0] == 2'b00)
				key_event(r[15:8] | 8'h80, r[20]);   // Outside the key table
			else
				key_event(key_table[r[7:4] % 9], r[20]);
			check_controls();
		end
		for (int i = 0; i < NUM_EVENTS; i++) begin
			r = rand32();
			if (r[0]) begin
				key_event(key_table[r[7:4] % 9], r[8]);
				check_controls();
			end
			r = rand32();
			joystick_0 = r[7:0];
			joystick_1 = r[15:8];
			rotate     = r[16];
			@(negedge clk_sys);
			check_controls();
		end
		joystick_0 = '0;
		joystick_1 = '0;
		rotate     = 1'b0;

		// ========================================
		// Overrun on back-to-back write edges
		// ========================================
		r   = rand32();
		idx = r % written.size();
		a   = written[idx];
		b   = written[(idx + 1) % written.size()];
		d2  = model_mem[b] ^ (r[15:8] | 8'h01);   // Differs from the stored byte
		dl_active = 1'b1;
		@(negedge clk_sys);
		dl_wr   = 1'b1;
		dl_addr = a;
		dl_data = r[31:24];
		@(negedge clk_sys);
		dl_wr = 1'b0;
		@(negedge clk_sys);
		dl_wr   = 1'b1;
		dl_addr = b;
		dl_data = d2;
		@(negedge clk_sys);
		dl_wr = 1'b0;
		model_mem[a] = r[31:24];
		wait_ack(1'b1, "wr_ack to rise on the overrun write");
		wait_ack(1'b0, "wr_ack to fall on the overrun write");
		check_value("load_overrun", 32'(load_overrun), 32'h1);
		dl_active = 1'b0;
		repeat (4) @(negedge clk_sys);
		check_value("load_overrun", 32'(load_overrun), 32'h1);
		check_value("rom_loaded", 32'(rom_loaded), 32'h1);
		check_read(a);
		check_read(b);

		$display("TB PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim/arcade_io_assert.sv
`default_nettype none

module arcade_io_assert (
	input logic clk_sys,
	input logic rst_n,
	input logic wr_req,
	input logic wr_ack,
	input logic rom_loaded,
	input logic core_reset
);

	timeunit 1ns;
	timeprecision 1ps;

	// ========================================
	// Write handshake
	// ========================================
	ack_needs_req: assert property (@(posedge clk_sys) disable iff (!rst_n)
		$rose(wr_ack) |-> $past(wr_req))
		else $error("wr_ack rose without a pending wr_req");

	req_held: assert property (@(posedge clk_sys) disable iff (!rst_n)
		wr_req && !wr_ack |=> wr_req)
		else $error("wr_req dropped before wr_ack");

	// No new request until ack is gone
	req_low_on_ack: assert property (@(posedge clk_sys) disable iff (!rst_n)
		!wr_req && wr_ack |=> !wr_req)
		else $error("wr_req rose while wr_ack was still high");

	// ========================================
	// Core reset
	// ========================================
	reset_until_loaded: assert property (@(posedge clk_sys) disable iff (!rst_n)
		!rom_loaded |=> core_reset)
		else $error("core_reset low while the ROM was not loaded");

endmodule

`default_nettype wire

//--- verilog/arcade_io_top.sv
`default_nettype none

module arcade_io_top (
	input  logic                  clk_sys,
	input  logic                  rst_n,
	input  logic                  key_strobe,
	input  logic                  key_pressed,
	input  input_pkg::scan_code_t key_code,
	input  input_pkg::joy_t       joystick_0,
	input  input_pkg::joy_t       joystick_1,
	input  logic                  rotate,
	input  logic                  user_reset,
	input  logic                  dl_active,
	input  logic                  dl_wr,
	input  rom_pkg::rom_addr_t    dl_addr,
	input  rom_pkg::rom_data_t    dl_data,
	input  rom_pkg::rom_addr_t    rom_rd_addr,
	output logic                  ctl_up,
	output logic                  ctl_down,
	output logic                  ctl_left,
	output logic                  ctl_right,
	output logic                  ctl_fire,
	output logic                  ctl_bomb,
	output logic                  ctl_coin,
	output logic                  ctl_start1,
	output logic                  ctl_start2,
	output rom_pkg::rom_data_t    rom_rd_data,
	output logic                  rom_loaded,
	output logic                  core_reset,
	output logic                  load_overrun
);

	import input_pkg::*;
	import rom_pkg::*;

	buttons_t  buttons;
	logic      wr_req;
	logic      wr_ack;
	rom_addr_t wr_addr;
	rom_data_t wr_data;

	// ========================================
	// Player controls
	// ========================================
	key_decoder u_key_decoder (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.key_strobe  (key_strobe),
		.key_pressed (key_pressed),
		.key_code    (key_code),
		.buttons     (buttons)
	);

	control_mapper u_control_mapper (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.rotate     (rotate),
		.buttons    (buttons),
		.joystick_0 (joystick_0),
		.joystick_1 (joystick_1),
		.ctl_up     (ctl_up),
		.ctl_down   (ctl_down),
		.ctl_left   (ctl_left),
		.ctl_right  (ctl_right),
		.ctl_fire   (ctl_fire),
		.ctl_bomb   (ctl_bomb),
		.ctl_coin   (ctl_coin),
		.ctl_start1 (ctl_start1),
		.ctl_start2 (ctl_start2)
	);

	// ========================================
	// ROM download path
	// ========================================
	load_sequencer u_load_sequencer (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.dl_active    (dl_active),
		.dl_wr        (dl_wr),
		.user_reset   (user_reset),
		.dl_addr      (dl_addr),
		.dl_data      (dl_data),
		.wr_req       (wr_req),
		.wr_addr      (wr_addr),
		.wr_data      (wr_data),
		.wr_ack       (wr_ack),
		.load_overrun (load_overrun),
		.rom_loaded   (rom_loaded),
		.core_reset   (core_reset)
	);

	rom_store u_rom_store (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.wr_req      (wr_req),
		.wr_addr     (wr_addr),
		.wr_data     (wr_data),
		.wr_ack      (wr_ack),
		.rom_rd_addr (rom_rd_addr),
		.rom_rd_data (rom_rd_data)
	);

endmodule

`default_nettype wire

//--- verilog/rom_store.sv
`default_nettype none

module rom_store (
	input  logic               clk_sys,
	input  logic               rst_n,
	input  logic               wr_req,
	input  rom_pkg::rom_addr_t wr_addr,
	input  rom_pkg::rom_data_t wr_data,
	output logic               wr_ack,
	input  rom_pkg::rom_addr_t rom_rd_addr,
	output rom_pkg::rom_data_t rom_rd_data
);

	import rom_pkg::*;

	localparam int ROM_DEPTH = 1 << $bits(rom_addr_t);

	rom_data_t mem [ROM_DEPTH];

	// Ack follows request one cycle later
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n)
			wr_ack <= 1'b0;
		else
			wr_ack <= wr_req;
	end

	// Write once per handshake, on the new request
	always_ff @(posedge clk_sys) begin
		if (wr_req && !wr_ack)
			mem[wr_addr] <= wr_data;
	end

	// Game side read port
	always_ff @(posedge clk_sys) begin
		rom_rd_data <= mem[rom_rd_addr];
	end

endmodule

`default_nettype wire

//--- verilog/load_sequencer.sv
`default_nettype none

module load_sequencer (
	input  logic                clk_sys,
	input  logic                rst_n,
	input  logic                dl_active,
	input  logic                dl_wr,
	input  logic                user_reset,
	input  rom_pkg::rom_addr_t  dl_addr,
	input  rom_pkg::rom_data_t  dl_data,
	output logic                wr_req,
	output rom_pkg::rom_addr_t  wr_addr,
	output rom_pkg::rom_data_t  wr_data,
	input  logic                wr_ack,
	output logic                load_overrun,
	output logic                rom_loaded,
	output logic                core_reset
);

	import rom_pkg::*;

	load_state_t state;
	logic        dl_wr_q;
	logic        dl_active_q;
	logic        dl_fall_q;   // End of download seen one cycle ago
	logic        wr_edge;

	assign wr_edge = dl_active & dl_wr & ~dl_wr_q;

	// ========================================
	// Edge detection
	// ========================================
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			dl_wr_q     <= 1'b0;
			dl_active_q <= 1'b0;
			dl_fall_q   <= 1'b0;
		end else begin
			dl_wr_q     <= dl_wr;
			dl_active_q <= dl_active;
			dl_fall_q   <= dl_active_q & ~dl_active;
		end
	end

	// ========================================
	// Four-phase write handshake
	// ========================================
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			state        <= IDLE;
			load_overrun <= 1'b0;
		end else begin
			case (state)
				IDLE: if (wr_edge) state <= REQ;
				REQ: if (wr_ack) state <= WAIT_ACK_LOW;
				WAIT_ACK_LOW: if (!wr_ack) state <= IDLE;
				default: state <= IDLE;
			endcase
			if (wr_edge && state != IDLE)
				load_overrun <= 1'b1;  // Sticky until reset
		end
	end

	// Address and data stay put for the whole handshake
	always_ff @(posedge clk_sys) begin
		if (wr_edge && state == IDLE) begin
			wr_addr <= dl_addr;
			wr_data <= dl_data;
		end
	end

	assign wr_req = (state == REQ);

	// ========================================
	// Load status and core reset
	// ========================================
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			rom_loaded <= 1'b0;
			core_reset <= 1'b1;
		end else begin
			if (dl_fall_q)
				rom_loaded <= 1'b1;
			core_reset <= user_reset | ~rom_loaded;
		end
	end

endmodule

`default_nettype wire

//--- verilog/control_mapper.sv
`default_nettype none

`include "arcade_params.svh"

module control_mapper (
	input  logic                clk_sys,
	input  logic                rst_n,
	input  logic                rotate,
	input  input_pkg::buttons_t buttons,
	input  input_pkg::joy_t     joystick_0,
	input  input_pkg::joy_t     joystick_1,
	output logic                ctl_up,
	output logic                ctl_down,
	output logic                ctl_left,
	output logic                ctl_right,
	output logic                ctl_fire,
	output logic                ctl_bomb,
	output logic                ctl_coin,
	output logic                ctl_start1,
	output logic                ctl_start2
);

	import input_pkg::*;

	logic raw_up, raw_down, raw_left, raw_right;
	logic raw_fire, raw_bomb;

	// Keyboard and both sticks share one player
	assign raw_up    = buttons[BTN_UP]    | joystick_0[`JOY_UP]    | joystick_1[`JOY_UP];
	assign raw_down  = buttons[BTN_DOWN]  | joystick_0[`JOY_DOWN]  | joystick_1[`JOY_DOWN];
	assign raw_left  = buttons[BTN_LEFT]  | joystick_0[`JOY_LEFT]  | joystick_1[`JOY_LEFT];
	assign raw_right = buttons[BTN_RIGHT] | joystick_0[`JOY_RIGHT] | joystick_1[`JOY_RIGHT];
	assign raw_fire  = buttons[BTN_FIRE1] | joystick_0[`JOY_FIRE]  | joystick_1[`JOY_FIRE];
	assign raw_bomb  = buttons[BTN_FIRE2] | joystick_0[`JOY_BOMB]  | joystick_1[`JOY_BOMB];

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			ctl_up     <= 1'b0;
			ctl_down   <= 1'b0;
			ctl_left   <= 1'b0;
			ctl_right  <= 1'b0;
			ctl_fire   <= 1'b0;
			ctl_bomb   <= 1'b0;
			ctl_coin   <= 1'b0;
			ctl_start1 <= 1'b0;
			ctl_start2 <= 1'b0;
		end else begin
			ctl_up     <= rotate ? raw_left  : raw_up;     // Rotated cabinet
			ctl_down   <= rotate ? raw_right : raw_down;
			ctl_left   <= rotate ? raw_down  : raw_left;
			ctl_right  <= rotate ? raw_up    : raw_right;
			ctl_fire   <= raw_fire;
			ctl_bomb   <= raw_bomb;
			ctl_coin   <= buttons[BTN_COIN];     // Keyboard only
			ctl_start1 <= buttons[BTN_START1];
			ctl_start2 <= buttons[BTN_START2];
		end
	end

endmodule

`default_nettype wire

//--- verilog/key_decoder.sv
`default_nettype none

`include "arcade_params.svh"

module key_decoder (
	input  logic                  clk_sys,
	input  logic                  rst_n,
	input  logic                  key_strobe,
	input  logic                  key_pressed,
	input  input_pkg::scan_code_t key_code,
	output input_pkg::buttons_t   buttons
);

	import input_pkg::*;

	buttons_t btn_q;  // Held state per key

	// Make sets a bit and break clears it
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			btn_q <= '0;
		end else if (key_strobe) begin
			case (key_code)
				`KEY_UP:     btn_q[BTN_UP]     <= key_pressed;
				`KEY_DOWN:   btn_q[BTN_DOWN]   <= key_pressed;
				`KEY_LEFT:   btn_q[BTN_LEFT]   <= key_pressed;
				`KEY_RIGHT:  btn_q[BTN_RIGHT]  <= key_pressed;
				`KEY_COIN:   btn_q[BTN_COIN]   <= key_pressed;
				`KEY_START1: btn_q[BTN_START1] <= key_pressed;
				`KEY_START2: btn_q[BTN_START2] <= key_pressed;
				`KEY_FIRE1:  btn_q[BTN_FIRE1]  <= key_pressed;
				`KEY_FIRE2:  btn_q[BTN_FIRE2]  <= key_pressed;
				default: begin
					// Unmapped key
				end
			endcase
		end
	end

	assign buttons = btn_q;

endmodule

`default_nettype wire

//--- verilog/rom_pkg.sv
`default_nettype none

`include "arcade_params.svh"

package rom_pkg;

	typedef logic [`ROM_ADDR_W-1:0] rom_addr_t;  // Byte address
	typedef logic [7:0]             rom_data_t;  // One ROM byte

	// Write handshake progress in the load sequencer
	typedef enum logic [1:0] {
		IDLE,
		REQ,          // Request up, waiting for ack
		WAIT_ACK_LOW  // Request down, waiting for ack to drop
	} load_state_t;

endpackage

`default_nettype wire

//--- verilog/input_pkg.sv
`default_nettype none

package input_pkg;

	typedef logic [7:0] scan_code_t;  // Keyboard scan code
	typedef logic [7:0] joy_t;        // Joystick word, active high
	typedef logic [8:0] buttons_t;    // Held keys

	// Bit positions inside buttons_t
	localparam int BTN_UP     = 0;
	localparam int BTN_DOWN   = 1;
	localparam int BTN_LEFT   = 2;
	localparam int BTN_RIGHT  = 3;
	localparam int BTN_COIN   = 4;
	localparam int BTN_START1 = 5;
	localparam int BTN_START2 = 6;
	localparam int BTN_FIRE1  = 7;
	localparam int BTN_FIRE2  = 8;

endpackage

`default_nettype wire

//--- include/arcade_params.svh
`ifndef ARCADE_PARAMS_SVH
`define ARCADE_PARAMS_SVH

// ========================================
// ROM geometry
// ========================================
`define ROM_ADDR_W 12             // Byte address width of the ROM store

// ========================================
// Joystick word bit positions
// ========================================
`define JOY_RIGHT  0
`define JOY_LEFT   1
`define JOY_DOWN   2
`define JOY_UP     3
`define JOY_FIRE   4
`define JOY_BOMB   5

// ========================================
// PS/2 set 2 scan codes
// ========================================
`define KEY_UP     8'h75          // Cursor up
`define KEY_DOWN   8'h72          // Cursor down
`define KEY_LEFT   8'h6b          // Cursor left
`define KEY_RIGHT  8'h74          // Cursor right
`define KEY_COIN   8'h76          // ESC
`define KEY_START1 8'h05          // F1
`define KEY_START2 8'h06          // F2
`define KEY_FIRE1  8'h29          // Space
`define KEY_FIRE2  8'h11          // Alt

`endif
